/* rtl/soc_pkg.sv */
package soc_pkg;

  // Widths with a meaning on the host side
  typedef logic [15:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [11:0] offset_t;

  // Each region spans 4 KiB
  localparam int REGION_BITS = 12;

  localparam addr_t SRAM_BASE   = 16'h0000;
  localparam addr_t SENSOR_BASE = 16'h1000;

  typedef enum logic [1:0] {
    SEL_SRAM,
    SEL_SENSOR,
    SEL_NONE
  } sel_t;

  typedef struct packed {
    logic    wr;
    offset_t offset;   // Byte offset inside the region
    word_t   wdata;
  } bus_cmd_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } bus_rsp_t;

  // Sensor register map
  localparam offset_t SNS_CTRL   = 12'h000;
  localparam offset_t SNS_STATUS = 12'h004;
  localparam offset_t SNS_CLEAR  = 12'h008;
  localparam offset_t SNS_DATA   = 12'h010;  // Sample i at SNS_DATA + 4*i

endpackage

/* rtl/reset_sync.sv */
`timescale 1ns/1ps

module reset_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic rst,
  output logic rst_sync
);

  logic [SYNC_STAGES-1:0] sync_q;

  // Assert at once, release through the flop chain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b0};
    end
  end

  assign rst_sync = sync_q[SYNC_STAGES-1];

endmodule

/* rtl/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              req,
  input  logic              wr,
  input  soc_pkg::addr_t    addr,
  input  soc_pkg::word_t    wdata,
  input  logic              ack,
  output soc_pkg::bus_cmd_t cmd,
  output logic              sram_start,
  output logic              sensor_start,
  output logic              miss
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_ACK,
    WAIT_REL
  } state_t;

  state_t state_q;
  state_t state_d;
  sel_t   sel_d;
  sel_t   sel_q;

  // Region select from the upper address bits
  always_comb begin
    if (addr[15:REGION_BITS] == SRAM_BASE[15:REGION_BITS]) begin
      sel_d = SEL_SRAM;
    end else if (addr[15:REGION_BITS] == SENSOR_BASE[15:REGION_BITS]) begin
      sel_d = SEL_SENSOR;
    end else begin
      sel_d = SEL_NONE;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (req) state_d = ISSUE;
      ISSUE:    state_d = WAIT_ACK;      // Start pulse goes out here
      WAIT_ACK: if (ack) state_d = WAIT_REL;
      WAIT_REL: if (!req) state_d = IDLE; // Host released, ack drops too
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      state_q <= IDLE;
      sel_q   <= SEL_NONE;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && req) sel_q <= sel_d;
    end
  end

  // Command fields are held for the whole access
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req) begin
      cmd.wr     <= wr;
      cmd.offset <= addr[REGION_BITS-1:0];
      cmd.wdata  <= wdata;
    end
  end

  assign sram_start   = (state_q == ISSUE) && (sel_q == SEL_SRAM);
  assign sensor_start = (state_q == ISSUE) && (sel_q == SEL_SENSOR);
  assign miss         = (state_q == ISSUE) && (sel_q == SEL_NONE);

endmodule

/* rtl/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave #(
  parameter int SRAM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              start,
  input  soc_pkg::bus_cmd_t cmd,
  output logic              done,
  output soc_pkg::bus_rsp_t rsp
);

  import soc_pkg::*;

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  word_t            mem [SRAM_WORDS];
  word_t            rdata_q;
  logic [9:0]       word_off;
  logic [IDX_W-1:0] idx;

  // Word index, wraps around the memory size
  assign word_off = cmd.offset[11:2];
  assign idx      = IDX_W'(word_off % SRAM_WORDS);

  always_ff @(posedge clk) begin
    if (start) begin
      if (cmd.wr) begin
        mem[idx] <= cmd.wdata;
        rdata_q  <= '0;
      end else begin
        rdata_q  <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      done <= 1'b0;
    end else begin
      done <= start;  // Single-cycle access
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.err   = 1'b0;     // No error case in plain memory

endmodule

/* rtl/sensor_slave.sv */
`timescale 1ns/1ps

module sensor_slave #(
  parameter int SENSOR_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              start,
  input  soc_pkg::bus_cmd_t cmd,
  input  logic              sensor_ready,
  input  soc_pkg::word_t    sensor_out,
  output logic              done,
  output soc_pkg::bus_rsp_t rsp,
  output logic              sensor_en,
  output logic              irq
);

  import soc_pkg::*;

  localparam int CNT_W = $clog2(SENSOR_DEPTH + 1);
  localparam int IDX_W = (SENSOR_DEPTH > 1) ? $clog2(SENSOR_DEPTH) : 1;

  word_t            smp_q [SENSOR_DEPTH];
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             capture;
  logic             capture_last;
  logic             data_hit;
  logic [9:0]       data_word;
  logic [IDX_W-1:0] data_idx;
  word_t            rd_data;
  logic             rd_err;
  logic             bus_wr;
  bus_rsp_t         rsp_q;

  assign full         = (count_q == CNT_W'(SENSOR_DEPTH));
  assign capture      = sensor_en && sensor_ready;
  assign capture_last = capture && (count_q == CNT_W'(SENSOR_DEPTH - 1));

  // Sample window decode
  assign data_word = 10'((cmd.offset - SNS_DATA) >> 2);
  assign data_idx  = data_word[IDX_W-1:0];
  assign data_hit  = (cmd.offset >= SNS_DATA) && (cmd.offset[1:0] == 2'b00) &&
                     (int'(cmd.offset) < int'(SNS_DATA) + 4 * SENSOR_DEPTH);

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (data_hit) begin
      rd_data = smp_q[data_idx];
      rd_err  = cmd.wr;          // Samples are read only
    end else begin
      case (cmd.offset)
        SNS_CTRL:   rd_data = {31'b0, sensor_en};
        SNS_STATUS: begin
          rd_data = {23'b0, full, 8'(count_q)};
          rd_err  = cmd.wr;
        end
        SNS_CLEAR:  rd_data = '0;
        default:    rd_err = 1'b1;
      endcase
    end
  end

  assign bus_wr = start && cmd.wr && !rd_err;

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      sensor_en <= 1'b0;
      irq       <= 1'b0;
      count_q   <= '0;
    end else begin
      if (capture) begin
        count_q <= count_q + 1'b1;
        if (capture_last) begin
          sensor_en <= 1'b0;     // Buffer full, stop the sensor
          irq       <= 1'b1;
        end
      end
      if (bus_wr && cmd.offset == SNS_CTRL) begin
        sensor_en <= cmd.wdata[0] & ~full & ~capture_last;
      end
      // Clear wins over a sample in the same cycle
      if (bus_wr && cmd.offset == SNS_CLEAR) begin
        count_q <= '0;
        irq     <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) smp_q[count_q[IDX_W-1:0]] <= sensor_out;
    if (start) begin
      rsp_q.rdata <= cmd.wr ? '0 : rd_data;
      rsp_q.err   <= rd_err;
    end
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  assign rsp = rsp_q;

endmodule

/* rtl/bus_result.sv */
`timescale 1ns/1ps

module bus_result (
  input  logic              clk,
  input  logic              rst_sync,
  input  logic              sram_done,
  input  soc_pkg::bus_rsp_t sram_rsp,
  input  logic              sensor_done,
  input  soc_pkg::bus_rsp_t sensor_rsp,
  input  logic              miss,
  input  logic              req,
  output logic              ack,
  output soc_pkg::word_t    rdata,
  output logic              err
);

  import soc_pkg::*;

  bus_rsp_t rsp_d;
  bus_rsp_t rsp_q;
  logic     finish;

  // Only one source finishes per access
  always_comb begin
    rsp_d = '{rdata: '0, err: 1'b1};   // Unmapped address
    if (sram_done) begin
      rsp_d = sram_rsp;
    end else if (sensor_done) begin
      rsp_d = sensor_rsp;
    end
  end

  assign finish = sram_done || sensor_done || miss;

  always_ff @(posedge clk) begin
    if (finish) rsp_q <= rsp_d;
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      ack <= 1'b0;
    end else if (finish) begin
      ack <= 1'b1;
    end else if (ack && !req) begin
      ack <= 1'b0;   // Return to zero after host release
    end
  end

  assign rdata = rsp_q.rdata;
  assign err   = rsp_q.err;

endmodule

/* rtl/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
  parameter int SRAM_WORDS   = 256,
  parameter int SENSOR_DEPTH = 4,
  parameter int SYNC_STAGES  = 2
) (
  input  logic           clk,
  input  logic           rst,
  // Host port
  input  logic           req,
  input  logic           wr,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::word_t wdata,
  output logic           ack,
  output soc_pkg::word_t rdata,
  output logic           err,
  // Sensor pins
  input  logic           sensor_ready,
  input  soc_pkg::word_t sensor_out,
  output logic           sensor_en,
  output logic           irq
);

  import soc_pkg::*;

  logic     rst_sync;
  bus_cmd_t cmd;
  logic     sram_start;
  logic     sensor_start;
  logic     miss;
  logic     sram_done;
  logic     sensor_done;
  bus_rsp_t sram_rsp;
  bus_rsp_t sensor_rsp;

  reset_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_reset_sync (
    .clk     (clk),
    .rst     (rst),
    .rst_sync(rst_sync)
  );

  bus_decode i_bus_decode (
    .clk         (clk),
    .rst_sync    (rst_sync),
    .req         (req),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .cmd         (cmd),
    .sram_start  (sram_start),
    .sensor_start(sensor_start),
    .miss        (miss)
  );

  sram_slave #(
    .SRAM_WORDS(SRAM_WORDS)
  ) i_sram_slave (
    .clk     (clk),
    .rst_sync(rst_sync),
    .start   (sram_start),
    .cmd     (cmd),
    .done    (sram_done),
    .rsp     (sram_rsp)
  );

  // Sensor wrapper with registered enable pin
  sensor_slave #(
    .SENSOR_DEPTH(SENSOR_DEPTH)
  ) i_sensor_slave (
    .clk         (clk),
    .rst_sync    (rst_sync),
    .start       (sensor_start),
    .cmd         (cmd),
    .sensor_ready(sensor_ready),
    .sensor_out  (sensor_out),
    .done        (sensor_done),
    .rsp         (sensor_rsp),
    .sensor_en   (sensor_en),
    .irq         (irq)
  );

  bus_result i_bus_result (
    .clk        (clk),
    .rst_sync   (rst_sync),
    .sram_done  (sram_done),
    .sram_rsp   (sram_rsp),
    .sensor_done(sensor_done),
    .sensor_rsp (sensor_rsp),
    .miss       (miss),
    .req        (req),
    .ack        (ack),
    .rdata      (rdata),
    .err        (err)
  );

endmodule

/* test/soc_asserts.sv */
`timescale 1ns/1ps

module soc_asserts (
  input logic clk,
  input logic rst_sync,
  input logic req,
  input logic ack
);

  int fail_count = 0;

  // ack was set on an edge where the host still held req
  property ack_needs_req;
    @(posedge clk) disable iff (rst_sync) $rose(ack) |-> $past(req);
  endproperty

  property ack_falls_after_release;
    @(posedge clk) disable iff (rst_sync) (ack && !req) |=> !ack;
  endproperty

  a_ack_needs_req: assert property (ack_needs_req) else begin
    fail_count++;
    $error("ack rose without a pending request");
  end

  a_ack_falls: assert property (ack_falls_after_release) else begin
    fail_count++;
    $error("ack did not fall one cycle after req fell");
  end

endmodule

// Same handshake rules seen from both ends of the internal path
bind bus_decode soc_asserts i_soc_asserts (
  .clk     (clk),
  .rst_sync(rst_sync),
  .req     (req),
  .ack     (ack)
);

bind bus_result soc_asserts i_soc_asserts (
  .clk     (clk),
  .rst_sync(rst_sync),
  .req     (req),
  .ack     (ack)
);

/* test/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker #(
  parameter int SRAM_WORDS   = 256,
  parameter int SENSOR_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           req,
  input  logic           wr,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::word_t wdata,
  input  logic           ack,
  input  soc_pkg::word_t rdata,
  input  logic           err,
  input  logic           sensor_ready,
  input  soc_pkg::word_t sensor_out,
  input  logic           sensor_en,
  input  logic           irq,
  output int             error_count,
  output int             check_count,
  output int             txn_count
);

  import soc_pkg::*;

  word_t    sram_model [SRAM_WORDS];
  word_t    sample_model [SENSOR_DEPTH];
  int       count_model = 0;
  logic     en_model = 1'b0;
  logic     irq_model = 1'b0;
  addr_t    txn_addr;
  logic     txn_wr;
  word_t    txn_wdata;
  logic     rst_q = 1'b1;
  logic     req_q = 1'b0;
  logic     ack_q = 1'b0;
  int       errors = 0;
  int       checks = 0;
  int       txns = 0;
  bus_rsp_t exp_rsp;

  assign error_count = errors;
  assign check_count = checks;
  assign txn_count   = txns;

  // Expected host response from the memory map and the models
  function automatic bus_rsp_t expect_rsp(input addr_t a, input logic is_wr);
    bus_rsp_t r;
    int       off;
    r.rdata = '0;
    r.err   = 1'b0;
    off     = int'(a[11:0]);
    if (a[15:12] == SRAM_BASE[15:12]) begin
      if (!is_wr) r.rdata = sram_model[(off / 4) % SRAM_WORDS];
    end else if (a[15:12] == SENSOR_BASE[15:12]) begin
      if (off >= int'(SNS_DATA) && off % 4 == 0 &&
          off < int'(SNS_DATA) + 4 * SENSOR_DEPTH) begin
        r.err = is_wr;                      // Samples are read only
        if (!is_wr) r.rdata = sample_model[(off - int'(SNS_DATA)) / 4];
      end else if (off == int'(SNS_CTRL)) begin
        if (!is_wr) r.rdata[0] = en_model;
      end else if (off == int'(SNS_STATUS)) begin
        r.err = is_wr;
        if (!is_wr) begin
          r.rdata[7:0] = 8'(count_model);
          r.rdata[8]   = (count_model == SENSOR_DEPTH);
        end
      end else if (off != int'(SNS_CLEAR)) begin
        r.err = 1'b1;
      end
    end else begin
      r.err = 1'b1;                         // Unmapped region
    end
    return r;
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_write();
    int off;
    off = int'(txn_addr[11:0]);
    if (txn_wr && txn_addr[15:12] == SRAM_BASE[15:12]) begin
      sram_model[(off / 4) % SRAM_WORDS] = txn_wdata;
    end else if (txn_wr && txn_addr[15:12] == SENSOR_BASE[15:12]) begin
      if (off == int'(SNS_CTRL)) en_model = txn_wdata[0] && (count_model < SENSOR_DEPTH);
      if (off == int'(SNS_CLEAR)) begin
        count_model = 0;
        irq_model   = 1'b0;
      end
    end
  endtask

  task automatic complete_txn();
    txns++;
    exp_rsp = expect_rsp(txn_addr, txn_wr);
    check_value("rdata", exp_rsp.rdata, rdata);
    check_value("err", word_t'(exp_rsp.err), word_t'(err));
    apply_write();
    // Pins already reflect a write by the time ack is seen
    check_value("sensor_en", word_t'(en_model), word_t'(sensor_en));
    check_value("irq", word_t'(irq_model), word_t'(irq));
  endtask

  always @(posedge clk) begin
    if (rst) begin
      count_model = 0;
      en_model    = 1'b0;
      irq_model   = 1'b0;
    end else begin
      if (rst_q) begin                      // First edge after reset release
        check_value("ack", '0, word_t'(ack));
        check_value("sensor_en", '0, word_t'(sensor_en));
        check_value("irq", '0, word_t'(irq));
      end
      if (req && !req_q) begin
        txn_addr  = addr;
        txn_wr    = wr;
        txn_wdata = wdata;
      end
      if (ack && !ack_q) complete_txn();
      if (en_model && sensor_ready && count_model < SENSOR_DEPTH) begin
        sample_model[count_model] = sensor_out;
        count_model++;
        if (count_model == SENSOR_DEPTH) begin
          en_model  = 1'b0;
          irq_model = 1'b1;
        end
      end
    end
    rst_q = rst;
    req_q = req;
    ack_q = ack;
  end

endmodule

/* test/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;

  import soc_pkg::*;

  localparam int SRAM_WORDS   = 256;
  localparam int SENSOR_DEPTH = 4;
  localparam int SYNC_STAGES  = 2;
  localparam int DRIVE_DLY    = 5;
  localparam int WAIT_LIMIT   = 20;    // Cycles per handshake phase
  localparam int SAMPLE_LIMIT = 200;

  logic   clk;
  logic   rst;
  logic   req;
  logic   wr;
  addr_t  addr;
  word_t  wdata;
  logic   ack;
  word_t  rdata;
  logic   err;
  logic   sensor_ready;
  word_t  sensor_out;
  logic   sensor_en;
  logic   irq;
  integer seed;
  int     timeouts;
  int     error_count;
  int     check_count;
  int     txn_count;
  int     assert_fails;
  addr_t  sram_addrs[$];

  always #50 clk = ~clk;

  soc_top #(
    .SRAM_WORDS  (SRAM_WORDS),
    .SENSOR_DEPTH(SENSOR_DEPTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) i_soc_top (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .err         (err),
    .sensor_ready(sensor_ready),
    .sensor_out  (sensor_out),
    .sensor_en   (sensor_en),
    .irq         (irq)
  );

  soc_checker #(
    .SRAM_WORDS  (SRAM_WORDS),
    .SENSOR_DEPTH(SENSOR_DEPTH)
  ) i_checker (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .err         (err),
    .sensor_ready(sensor_ready),
    .sensor_out  (sensor_out),
    .sensor_en   (sensor_en),
    .irq         (irq),
    .error_count (error_count),
    .check_count (check_count),
    .txn_count   (txn_count)
  );

  function automatic addr_t reg_addr(input offset_t off);
    return SENSOR_BASE + addr_t'(off);
  endfunction

  task automatic wait_ack(input logic level, input addr_t a);
    int n;
    n = 0;
    while (ack !== level && n < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    if (ack !== level) begin
      timeouts++;
      $display("Timeout at %0t: ack never went to %0b for address %h", $time, level, a);
    end
  endtask

  // One full four-phase host transaction
  task automatic host_access(input logic is_wr, input addr_t a, input word_t d);
    @(posedge clk);
    #DRIVE_DLY;
    req   = 1'b1;
    wr    = is_wr;
    addr  = a;
    wdata = d;
    wait_ack(1'b1, a);
    req = 1'b0;
    wait_ack(1'b0, a);
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    host_access(1'b1, a, d);
  endtask

  task automatic read_word(input addr_t a);
    host_access(1'b0, a, '0);
  endtask

  // Random sensor_ready gaps until n samples were taken
  task automatic feed_samples(input int n);
    int got;
    int cycles;
    got    = 0;
    cycles = 0;
    while (got < n && cycles < SAMPLE_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      sensor_ready = 1'($random(seed));
      sensor_out   = $random(seed);
      if (sensor_ready && sensor_en) got++;   // Taken on the coming edge
      cycles++;
    end
    @(posedge clk);
    #DRIVE_DLY;
    sensor_ready = 1'b0;
    if (got < n) begin
      timeouts++;
      $display("Timeout at %0t: sensor delivered only %0d of %0d samples", $time, got, n);
    end
  endtask

  initial begin
    addr_t a;
    addr_t alias_a;
    seed         = 32;
    clk          = 1'b0;
    rst          = 1'b1;
    req          = 1'b0;
    wr           = 1'b0;
    addr         = '0;
    wdata        = '0;
    sensor_ready = 1'b0;
    sensor_out   = '0;
    timeouts     = 0;
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    repeat (SYNC_STAGES + 2) @(posedge clk);

    // SRAM writes, read back directly and through an alias
    for (int i = 0; i < 12; i++) begin
      a = {4'h0, 10'($random(seed)), 2'b00};
      write_word(a, $random(seed));
      sram_addrs.push_back(a);
    end
    foreach (sram_addrs[i]) begin
      read_word(sram_addrs[i]);
      alias_a = addr_t'((int'(sram_addrs[i]) + SRAM_WORDS * 4) % 4096);
      read_word(alias_a);
    end

    // Unmapped regions
    read_word(16'h2000);
    write_word(16'h8004, $random(seed));
    read_word(16'hF000);

    // Sensor partial fill
    write_word(reg_addr(SNS_CTRL), 32'h1);
    read_word(reg_addr(SNS_CTRL));
    feed_samples(2);
    read_word(reg_addr(SNS_STATUS));
    read_word(reg_addr(SNS_DATA));
    read_word(reg_addr(SNS_DATA + 12'h004));

    // Fill to the end, then check the full buffer
    feed_samples(SENSOR_DEPTH - 2);
    read_word(reg_addr(SNS_STATUS));
    for (int i = 0; i < SENSOR_DEPTH; i++) begin
      read_word(reg_addr(SNS_DATA + offset_t'(4 * i)));
    end
    read_word(reg_addr(SNS_DATA + offset_t'(4 * SENSOR_DEPTH)));
    read_word(reg_addr(12'h00C));
    write_word(reg_addr(SNS_CLEAR), '0);
    read_word(reg_addr(SNS_STATUS));
    write_word(reg_addr(SNS_STATUS), 32'h5);
    repeat (3) @(posedge clk);

    assert_fails = i_soc_top.i_bus_decode.i_soc_asserts.fail_count +
                   i_soc_top.i_bus_result.i_soc_asserts.fail_count;
    $display("Transactions %0d, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             txn_count, check_count, error_count, timeouts, assert_fails);
    if (error_count == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* soc_lite.f */
rtl/soc_pkg.sv
rtl/reset_sync.sv
rtl/bus_decode.sv
rtl/sram_slave.sv
rtl/sensor_slave.sv
rtl/bus_result.sv
rtl/soc_top.sv
test/soc_asserts.sv
test/soc_checker.sv
test/tb_soc_top.sv

/* Makefile */
# Verilator flow for soc_lite
VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= soc_lite.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
